// ==== hw/pd_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants and types for the packet decoder
// Digest is FNV-1a, not a cryptographic hash
// One block is two 32-byte DATA packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pd_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  pid_t;
	typedef logic [6:0]  addr_t;
	typedef logic [5:0]  blk_idx_t;
	typedef logic [31:0] digest_t;

	// Token and data PIDs with the low nibble complementing the high nibble
	localparam pid_t PID_IN    = 8'h69;
	localparam pid_t PID_OUT   = 8'hE1;
	localparam pid_t PID_DATA0 = 8'hC3;
	localparam pid_t PID_DATA1 = 8'h4B;

	localparam byte_t TYPE_INTERRUPT = 8'h00;
	localparam byte_t TYPE_HASH      = 8'hFF;

	localparam addr_t EP_ADDR = 7'b1100001;

	localparam int PKT_BYTES   = 32;
	localparam int BLOCK_BYTES = 64;

	localparam digest_t FNV_INIT  = 32'h811C9DC5;
	localparam digest_t FNV_PRIME = 32'h01000193;

	typedef enum logic [3:0] {
		ST_IDLE, ST_ADDR_IN, ST_IN_EOP, ST_HOST_READY,
		ST_ADDR_OUT, ST_DRAIN, ST_DATA_TYPE, ST_PAYLOAD1,
		ST_PAYLOAD2, ST_ACK_EOP, ST_BLOCK_EOP, ST_ACK_END,
		ST_TX_ACK, ST_NACK_EOP, ST_NACK_END, ST_TX_NACK
	} ctrl_state_e;

	typedef enum logic [1:0] {
		DG_IDLE, DG_READ, DG_DONE, DG_RELEASE
	} dig_state_e;

endpackage

// ==== hw/pd_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet decode FSM for the hash endpoint
// Each byte is acted on the cycle after its strobe
// i_eop must be held high for two cycles
// DATA PIDs are NACKed while the buffer is busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pd_controller import pd_pkg::*; (
	input  logic  clk,
	input  logic  n_rst,
	input  logic  i_write_enable,
	input  byte_t i_rx_data,
	input  logic  i_eop,
	input  logic  i_rcv_error,
	input  logic  i_packet_done,
	input  logic  i_busy,
	output logic  o_wr_en,
	output byte_t o_wr_data,
	output logic  o_restart,
	output logic  o_block_end,
	output logic  o_host_ready,
	output logic  o_transmit_ack,
	output logic  o_transmit_nack,
	output logic  o_p_error
);

	ctrl_state_e state, next_state;

	byte_t rx_byte;
	logic  byte_vld;
	logic  valid_address;
	logic  addr_set;
	logic  addr_clr;
	logic  pkt_abort;
	pid_t  pid;
	addr_t addr;

	// Byte captured on its strobe
	always_ff @(posedge clk) begin
		if (i_write_enable)
			rx_byte <= i_rx_data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state         <= ST_IDLE;
			byte_vld      <= 1'b0;
			valid_address <= 1'b0;
		end else begin
			state    <= next_state;
			byte_vld <= i_write_enable;
			if (addr_set)
				valid_address <= 1'b1;
			else if (addr_clr)
				valid_address <= 1'b0;
		end
	end

	assign pid       = rx_byte;
	assign addr      = rx_byte[7:1];
	assign o_wr_data = rx_byte;

	// Line error, or EOP before the packet is complete
	assign pkt_abort = i_rcv_error || (i_eop && !byte_vld);

	always_comb begin
		next_state      = state;
		o_wr_en         = 1'b0;
		o_restart       = 1'b0;
		o_block_end     = 1'b0;
		o_host_ready    = 1'b0;
		o_transmit_ack  = 1'b0;
		o_transmit_nack = 1'b0;
		o_p_error       = 1'b0;
		addr_set        = 1'b0;
		addr_clr        = 1'b0;
		case (state)
			ST_IDLE: begin
				if (byte_vld) begin
					if (pid[3:0] != ~pid[7:4]) begin
						o_p_error  = 1'b1;
						next_state = i_eop ? ST_NACK_END : ST_NACK_EOP;
					end else if (pid == PID_IN) begin
						next_state = ST_ADDR_IN;
					end else if (pid == PID_OUT) begin
						next_state = ST_ADDR_OUT;
					end else if (pid == PID_DATA0 || pid == PID_DATA1) begin
						if (!valid_address) begin
							next_state = ST_DRAIN;
						end else if (i_busy) begin
							next_state = ST_NACK_EOP;
						end else if (pid == PID_DATA0) begin
							o_restart  = 1'b1;
							next_state = ST_DATA_TYPE;
						end else begin
							next_state = ST_PAYLOAD2;
						end
					end else begin
						next_state = ST_DRAIN;
					end
				end
			end
			ST_ADDR_IN: begin
				if (byte_vld) begin
					if (addr != EP_ADDR)
						next_state = ST_DRAIN;
					else if (i_eop)
						next_state = ST_HOST_READY;
					else
						next_state = ST_IN_EOP;
				end else if (pkt_abort) begin
					o_p_error  = 1'b1;
					next_state = i_eop ? ST_NACK_END : ST_NACK_EOP;
				end
			end
			ST_IN_EOP: begin
				if (i_eop)
					next_state = ST_HOST_READY;
			end
			ST_HOST_READY: begin
				o_host_ready = 1'b1;
				next_state   = ST_IDLE;
			end
			ST_ADDR_OUT: begin
				if (byte_vld) begin
					addr_set   = (addr == EP_ADDR);
					addr_clr   = (addr != EP_ADDR);
					next_state = ST_DRAIN;
				end else if (pkt_abort) begin
					o_p_error  = 1'b1;
					next_state = i_eop ? ST_NACK_END : ST_NACK_EOP;
				end
			end
			ST_DRAIN: begin
				if (i_eop)
					next_state = ST_IDLE;
			end
			ST_DATA_TYPE: begin
				if (pkt_abort || (byte_vld && rx_byte != TYPE_HASH &&
						rx_byte != TYPE_INTERRUPT)) begin
					o_p_error  = 1'b1;
					next_state = i_eop ? ST_NACK_END : ST_NACK_EOP;
				end else if (byte_vld && rx_byte == TYPE_HASH) begin
					next_state = ST_PAYLOAD1;
				end else if (byte_vld) begin
					o_restart  = 1'b1;
					next_state = ST_ACK_EOP;
				end
			end
			ST_PAYLOAD1, ST_PAYLOAD2: begin
				if (pkt_abort) begin
					o_p_error  = 1'b1;
					next_state = i_eop ? ST_NACK_END : ST_NACK_EOP;
				end else if (byte_vld) begin
					o_wr_en = 1'b1;
					if (i_packet_done)
						next_state = (state == ST_PAYLOAD1) ? ST_ACK_EOP : ST_BLOCK_EOP;
				end
			end
			ST_ACK_EOP: begin
				if (i_eop)
					next_state = ST_ACK_END;
			end
			ST_BLOCK_EOP: begin
				if (i_eop) begin
					o_block_end = 1'b1;
					next_state  = ST_ACK_END;
				end
			end
			ST_ACK_END: begin
				if (!i_eop)
					next_state = ST_TX_ACK;
			end
			ST_TX_ACK: begin
				o_transmit_ack = 1'b1;
				next_state     = ST_IDLE;
			end
			ST_NACK_EOP: begin
				if (i_eop)
					next_state = ST_NACK_END;
			end
			ST_NACK_END: begin
				if (!i_eop)
					next_state = ST_TX_NACK;
			end
			ST_TX_NACK: begin
				o_transmit_nack = 1'b1;
				next_state      = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	// Buffer contents stay frozen during a block handoff
	a_no_write_busy: assert property (@(posedge clk) disable iff (!n_rst)
		!(o_wr_en && i_busy));

endmodule

// ==== hw/pd_block_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-byte block store with req side of the handoff
// Only a completely written block is handed off
// Read data has one cycle of latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pd_block_buffer import pd_pkg::*; (
	input  logic     clk,
	input  logic     n_rst,
	input  logic     i_wr_en,
	input  byte_t    i_wr_data,
	input  logic     i_restart,
	input  logic     i_block_end,
	input  blk_idx_t i_rd_idx,
	input  logic     i_blk_ack,
	output logic     o_packet_done,
	output logic     o_busy,
	output logic     o_blk_req,
	output byte_t    o_rd_data
);

	byte_t    mem [BLOCK_BYTES];
	blk_idx_t wr_cnt;
	logic     blk_full;

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[wr_cnt] <= i_wr_data;
		o_rd_data <= mem[i_rd_idx];
	end

	// Last byte of either 32-byte half
	assign o_packet_done = i_wr_en && (wr_cnt[4:0] == 5'(PKT_BYTES - 1));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_cnt    <= '0;
			blk_full  <= 1'b0;
			o_blk_req <= 1'b0;
			o_busy    <= 1'b0;
		end else begin
			if (i_restart) begin
				wr_cnt   <= '0;
				blk_full <= 1'b0;
			end else if (i_wr_en) begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == blk_idx_t'(BLOCK_BYTES - 1))
					blk_full <= 1'b1;
			end

			// Busy holds until the four-phase cycle ends
			if (i_block_end && blk_full && !o_busy) begin
				o_blk_req <= 1'b1;
				o_busy    <= 1'b1;
				blk_full  <= 1'b0;
			end else if (o_blk_req && i_blk_ack) begin
				o_blk_req <= 1'b0;
			end else if (o_busy && !o_blk_req && !i_blk_ack) begin
				o_busy <= 1'b0;
			end
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (!n_rst)
		o_blk_req && !i_blk_ack |=> o_blk_req);

endmodule

// ==== hw/pd_digest.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FNV-1a digest over one 64-byte block
// Ack rises BLOCK_BYTES+2 cycles after req
// o_digest holds the last result until the next one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pd_digest import pd_pkg::*; (
	input  logic     clk,
	input  logic     n_rst,
	input  logic     i_blk_req,
	input  byte_t    i_rd_data,
	output blk_idx_t o_rd_idx,
	output logic     o_blk_ack,
	output digest_t  o_digest,
	output logic     o_digest_valid
);

	dig_state_e state;
	digest_t    acc;
	digest_t    acc_next;
	logic       rd_vld;
	logic       last_byte;

	assign acc_next = (acc ^ {24'd0, i_rd_data}) * FNV_PRIME;

	// Index wraps to zero exactly when byte 63 is on the read port
	assign last_byte = rd_vld && (o_rd_idx == '0);

	always_ff @(posedge clk) begin
		if (state == DG_IDLE && i_blk_req)
			acc <= FNV_INIT;
		else if (state == DG_READ && rd_vld)
			acc <= acc_next;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state          <= DG_IDLE;
			o_rd_idx       <= '0;
			rd_vld         <= 1'b0;
			o_blk_ack      <= 1'b0;
			o_digest       <= FNV_INIT;
			o_digest_valid <= 1'b0;
		end else begin
			o_digest_valid <= 1'b0;
			case (state)
				DG_IDLE: begin
					if (i_blk_req) begin
						o_rd_idx <= '0;
						rd_vld   <= 1'b0;
						state    <= DG_READ;
					end
				end
				DG_READ: begin
					o_rd_idx <= o_rd_idx + 1'b1;
					rd_vld   <= 1'b1;
					if (last_byte) begin
						o_digest       <= acc_next;
						o_blk_ack      <= 1'b1;
						o_digest_valid <= 1'b1;
						rd_vld         <= 1'b0;
						state          <= DG_DONE;
					end
				end
				DG_DONE: begin
					if (!i_blk_req) begin
						o_blk_ack <= 1'b0;
						state     <= DG_RELEASE;
					end
				end
				DG_RELEASE: state <= DG_IDLE;
				default:    state <= DG_IDLE;
			endcase
		end
	end

	a_ack_release: assert property (@(posedge clk) disable iff (!n_rst)
		$fell(o_blk_ack) |-> !$past(i_blk_req));

endmodule

// ==== hw/pd_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive side of the hash endpoint
// Expects a decoded byte stream, no CRC check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pd_top import pd_pkg::*; (
	input  logic    clk,
	input  logic    n_rst,
	input  byte_t   i_rx_data,
	input  logic    i_write_enable,
	input  logic    i_eop,
	input  logic    i_rcv_error,
	output logic    o_host_ready,
	output logic    o_transmit_ack,
	output logic    o_transmit_nack,
	output logic    o_p_error,
	output digest_t o_digest,
	output logic    o_digest_valid
);

	logic     wr_en;
	byte_t    wr_data;
	logic     restart;
	logic     block_end;
	logic     packet_done;
	logic     busy;
	logic     blk_req;
	logic     blk_ack;
	blk_idx_t rd_idx;
	byte_t    rd_data;

	pd_controller u_controller (
		.clk             (clk),
		.n_rst           (n_rst),
		.i_write_enable  (i_write_enable),
		.i_rx_data       (i_rx_data),
		.i_eop           (i_eop),
		.i_rcv_error     (i_rcv_error),
		.i_packet_done   (packet_done),
		.i_busy          (busy),
		.o_wr_en         (wr_en),
		.o_wr_data       (wr_data),
		.o_restart       (restart),
		.o_block_end     (block_end),
		.o_host_ready    (o_host_ready),
		.o_transmit_ack  (o_transmit_ack),
		.o_transmit_nack (o_transmit_nack),
		.o_p_error       (o_p_error)
	);

	pd_block_buffer u_buffer (
		.clk           (clk),
		.n_rst         (n_rst),
		.i_wr_en       (wr_en),
		.i_wr_data     (wr_data),
		.i_restart     (restart),
		.i_block_end   (block_end),
		.i_rd_idx      (rd_idx),
		.i_blk_ack     (blk_ack),
		.o_packet_done (packet_done),
		.o_busy        (busy),
		.o_blk_req     (blk_req),
		.o_rd_data     (rd_data)
	);

	pd_digest u_digest (
		.clk            (clk),
		.n_rst          (n_rst),
		.i_blk_req      (blk_req),
		.i_rd_data      (rd_data),
		.o_rd_idx       (rd_idx),
		.o_blk_ack      (blk_ack),
		.o_digest       (o_digest),
		.o_digest_valid (o_digest_valid)
	);

endmodule

// ==== dv/tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock with a 4 ns period
// Reset is held low for the first 5 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk,
	output logic n_rst
);

	initial begin
		clk   = 1'b0;
		n_rst = 1'b0;
		repeat (5) @(negedge clk);
		n_rst = 1'b1;
	end

	always #2 clk = ~clk;

endmodule

// ==== dv/tb_pd_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response and digest checker for pd_top
// Samples DUT outputs on the rising edge
// Digests are compared in arrival order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_pd_checker import pd_pkg::*; (
	input logic    clk,
	input logic    n_rst,
	input logic    i_host_ready,
	input logic    i_transmit_ack,
	input logic    i_transmit_nack,
	input logic    i_p_error,
	input digest_t i_digest,
	input logic    i_digest_valid
);

	localparam digest_t FNV_OFFSET = 32'h811C9DC5;
	localparam digest_t FNV_MULT   = 32'h01000193;

	string resp_q[$];
	byte_t blk_q[$];
	string test_name   = "reset";
	logic  perr_seen   = 1'b0;
	int    check_count = 0;
	int    error_count = 0;

	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic expect_response(input string kind);
		resp_q.push_back(kind);
	endtask

	task automatic expect_byte(input byte_t b);
		blk_q.push_back(b);
	endtask

	function automatic int responses_pending();
		return resp_q.size();
	endfunction

	function automatic int bytes_pending();
		return blk_q.size();
	endfunction

	// FNV-1a over the oldest queued block
	function automatic digest_t ref_digest();
		digest_t h;
		int      i;
		h = FNV_OFFSET;
		for (i = 0; i < BLOCK_BYTES; i++)
			h = (h ^ {24'd0, blk_q[i]}) * FNV_MULT;
		return h;
	endfunction

	task automatic check_reset_state();
		check_count++;
		if (i_digest !== FNV_OFFSET) begin
			error_count++;
			$display("ERR %s: expected digest %h, actual %h", test_name, FNV_OFFSET,
				i_digest);
		end
		if (i_digest_valid !== 1'b0) begin
			error_count++;
			$display("ERR %s: expected digest_valid 0, actual %b", test_name,
				i_digest_valid);
		end
	endtask

	task automatic check_pulse(input string actual);
		string exp;
		string act;
		check_count++;
		if (resp_q.size() == 0) begin
			error_count++;
			$display("Unexpected %s pulse during %s", actual, test_name);
		end else if (actual == "p_error") begin
			if (resp_q[0] != "p_error+nack" || perr_seen) begin
				error_count++;
				$display("ERR %s: expected %s, actual p_error", test_name, resp_q[0]);
			end
			perr_seen = 1'b1;
		end else begin
			exp = resp_q.pop_front();
			act = perr_seen ? {"p_error+", actual} : actual;
			if (act != exp) begin
				error_count++;
				$display("ERR %s: expected %s, actual %s", test_name, exp, act);
			end
			perr_seen = 1'b0;
		end
	endtask

	task automatic check_digest();
		digest_t exp;
		check_count++;
		if (blk_q.size() < BLOCK_BYTES) begin
			error_count++;
			$display("Unexpected digest output during %s", test_name);
		end else begin
			exp = ref_digest();
			repeat (BLOCK_BYTES) blk_q.delete(0);
			if (i_digest !== exp) begin
				error_count++;
				$display("ERR %s: expected digest %h, actual %h", test_name, exp, i_digest);
			end
		end
	endtask

	always @(posedge clk) begin
		if (n_rst) begin
			if (i_p_error)
				check_pulse("p_error");
			if (i_host_ready)
				check_pulse("host_ready");
			if (i_transmit_ack)
				check_pulse("ack");
			if (i_transmit_nack)
				check_pulse("nack");
			if (i_digest_valid)
				check_digest();
		end
	end

endmodule

// ==== dv/tb_pd_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the hash endpoint receive side
// Inputs change on the falling clock edge
// Token address byte carries the address in bits 7:1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_pd_top import pd_pkg::*; ();

	localparam int MAX_GAP         = 3;
	localparam int N_RAND_BLOCKS   = 4;
	localparam int DATA0_BYTES     = PKT_BYTES + 2;
	localparam int DATA1_BYTES     = PKT_BYTES + 1;
	localparam int BLOCK_PKT_BYTES = DATA0_BYTES + DATA1_BYTES;
	// Bytes of each test in run order
	localparam int STIM_BYTES = 1 + 4 + DATA0_BYTES
		+ 2 + N_RAND_BLOCKS * BLOCK_PKT_BYTES
		+ DATA0_BYTES + 2 + DATA1_BYTES + BLOCK_PKT_BYTES
		+ BLOCK_PKT_BYTES + DATA0_BYTES;
	// One extra slot for the window that watches for a stray digest
	localparam int N_BLOCKS       = N_RAND_BLOCKS + 3;
	localparam int TIMEOUT_CYCLES = STIM_BYTES * (MAX_GAP + 1) + 100 * N_BLOCKS;

	logic    clk;
	logic    n_rst;
	byte_t   rx_data;
	logic    write_enable;
	logic    eop;
	logic    rcv_error;
	logic    host_ready;
	logic    transmit_ack;
	logic    transmit_nack;
	logic    p_error;
	digest_t digest;
	logic    digest_valid;
	integer  seed;
	int      cycles = 0;
	byte_t   pkt[$];

	tb_clkgen u_clkgen (
		.clk   (clk),
		.n_rst (n_rst)
	);

	pd_top uut (
		.clk             (clk),
		.n_rst           (n_rst),
		.i_rx_data       (rx_data),
		.i_write_enable  (write_enable),
		.i_eop           (eop),
		.i_rcv_error     (rcv_error),
		.o_host_ready    (host_ready),
		.o_transmit_ack  (transmit_ack),
		.o_transmit_nack (transmit_nack),
		.o_p_error       (p_error),
		.o_digest        (digest),
		.o_digest_valid  (digest_valid)
	);

	tb_pd_checker u_checker (
		.clk             (clk),
		.n_rst           (n_rst),
		.i_host_ready    (host_ready),
		.i_transmit_ack  (transmit_ack),
		.i_transmit_nack (transmit_nack),
		.i_p_error       (p_error),
		.i_digest        (digest),
		.i_digest_valid  (digest_valid)
	);

	task automatic send_byte(input byte_t b);
		int gap;
		gap = $unsigned($random(seed)) % (MAX_GAP + 1);
		repeat (gap) @(negedge clk);
		write_enable = 1'b1;
		rx_data      = b;
		@(negedge clk);
		write_enable = 1'b0;
	endtask

	// EOP is held two cycles, then the line idles
	task automatic send_packet();
		foreach (pkt[i])
			send_byte(pkt[i]);
		@(negedge clk);
		eop = 1'b1;
		repeat (2) @(negedge clk);
		eop = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic send_token(input pid_t pid, input addr_t addr);
		pkt.delete();
		pkt.push_back(pid);
		pkt.push_back({addr, 1'b0});
		send_packet();
	endtask

	task automatic send_data(input pid_t pid, input logic expect_digest);
		byte_t b;
		pkt.delete();
		pkt.push_back(pid);
		if (pid == PID_DATA0)
			pkt.push_back(TYPE_HASH);
		repeat (PKT_BYTES) begin
			b = byte_t'($random(seed));
			pkt.push_back(b);
			if (expect_digest)
				u_checker.expect_byte(b);
		end
		send_packet();
	endtask

	task automatic wait_responses();
		while (u_checker.responses_pending() != 0)
			@(negedge clk);
	endtask

	task automatic wait_digests();
		while (u_checker.bytes_pending() != 0)
			@(negedge clk);
		// Handoff finishes a few cycles after the digest
		repeat (4) @(negedge clk);
	endtask

	task automatic send_block();
		u_checker.expect_response("ack");
		send_data(PID_DATA0, 1'b1);
		wait_responses();
		u_checker.expect_response("ack");
		send_data(PID_DATA1, 1'b1);
		wait_responses();
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		seed         = 32'ha775fdd1;
		rx_data      = '0;
		write_enable = 1'b0;
		eop          = 1'b0;
		rcv_error    = 1'b0;
		wait (n_rst === 1'b1);
		@(negedge clk);
		u_checker.check_reset_state();

		u_checker.set_test("bad_pid");
		u_checker.expect_response("p_error+nack");
		pkt.delete();
		pkt.push_back(8'h12);
		send_packet();
		wait_responses();

		u_checker.set_test("in_token");
		u_checker.expect_response("host_ready");
		send_token(PID_IN, EP_ADDR);
		wait_responses();
		send_token(PID_IN, ~EP_ADDR);
		repeat (10) @(negedge clk);

		// Dropped because no OUT has named the endpoint
		u_checker.set_test("data_no_out");
		send_data(PID_DATA0, 1'b0);
		repeat (10) @(negedge clk);

		u_checker.set_test("hash_blocks");
		send_token(PID_OUT, EP_ADDR);
		repeat (N_RAND_BLOCKS) begin
			send_block();
			wait_digests();
		end

		u_checker.set_test("interrupt");
		u_checker.expect_response("ack");
		send_data(PID_DATA0, 1'b0);
		wait_responses();
		u_checker.expect_response("ack");
		pkt.delete();
		pkt.push_back(PID_DATA0);
		pkt.push_back(TYPE_INTERRUPT);
		send_packet();
		wait_responses();
		// DATA1 alone cannot complete the abandoned block
		u_checker.expect_response("ack");
		send_data(PID_DATA1, 1'b0);
		wait_responses();
		repeat (BLOCK_BYTES + 10) @(negedge clk);
		send_block();
		wait_digests();

		// DATA0 lands while the block is still handed off
		u_checker.set_test("busy_nack");
		send_block();
		u_checker.expect_response("nack");
		send_data(PID_DATA0, 1'b0);
		wait_responses();
		wait_digests();

		repeat (20) @(negedge clk);
		$display("Checks: %0d, errors: %0d", u_checker.check_count, u_checker.error_count);
		if (u_checker.error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
hw/pd_pkg.sv
hw/pd_controller.sv
hw/pd_block_buffer.sv
hw/pd_digest.sv
hw/pd_top.sv
dv/tb_clkgen.sv
dv/tb_pd_checker.sv
dv/tb_pd_top.sv

// ==== Bender.yml ====
package:
  name: pd_hash_endpoint

sources:
  - files:
      - hw/pd_pkg.sv
      - hw/pd_controller.sv
      - hw/pd_block_buffer.sv
      - hw/pd_digest.sv
      - hw/pd_top.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/tb_pd_checker.sv
      - dv/tb_pd_top.sv
